//--- common/branchPkg.sv
`default_nettype none

package branchPkg;

	// ==============================
	// widths
	// ==============================
	localparam int dataWidth = 64;
	localparam int irWidth = 32;
	// slots per issue group
	localparam int laneCount = 2;

	typedef logic [$clog2(laneCount)-1:0] laneIdxT;

	// ==============================
	// major opcodes, ir[31:25]
	// ==============================
	localparam logic [6:0] opBtrr = 7'd16;
	localparam logic [6:0] opBtri = 7'd17;
	localparam logic [6:0] opTrapcc = 7'd24;
	localparam logic [6:0] opTrapcci = 7'd25;
	// single-opcode immediate branches
	localparam logic [6:0] opBeqi = 7'd64;
	localparam logic [6:0] opBnei = 7'd65;
	localparam logic [6:0] opBlti = 7'd66;
	localparam logic [6:0] opBlei = 7'd67;
	localparam logic [6:0] opBgti = 7'd68;
	localparam logic [6:0] opBgei = 7'd69;
	localparam logic [6:0] opBltui = 7'd70;
	localparam logic [6:0] opBleui = 7'd71;
	localparam logic [6:0] opBgtui = 7'd72;
	localparam logic [6:0] opBgeui = 7'd73;

	// unified condition, numbered like the btrr function code
	typedef enum logic [3:0] {
		condAlways = 4'd0,
		condNever = 4'd1,
		condEq = 4'd2,
		condNe = 4'd3,
		condLt = 4'd4,
		condLe = 4'd5,
		condGt = 4'd6,
		condGe = 4'd7,
		condLtu = 4'd8,
		condLeu = 4'd9,
		condGtu = 4'd10,
		condGeu = 4'd11,
		condOr = 4'd12,
		condAnd = 4'd13,
		condNr = 4'd14,
		condLoop = 4'd15
	} condT;

	// btri only reaches the compare codes
	localparam logic [3:0] btriCodeLimit = 4'd12;
	// trap code k maps to condEq + k, up to condGeu
	localparam logic [3:0] trapCodeMax = 4'd9;

	typedef enum logic [1:0] {
		kindNone = 2'd0,
		kindBranch = 2'd1,
		kindTrap = 2'd2
	} kindT;

	// ==============================
	// slot payloads
	// ==============================
	typedef struct packed {
		logic valid;
		logic [irWidth-1:0] ir;
		logic [dataWidth-1:0] a;
		logic [dataWidth-1:0] b;
		logic [dataWidth-1:0] imm;
		logic [dataWidth-1:0] target;
	} slotInT;

	typedef struct packed {
		logic valid;
		kindT kind;
		condT cond;
		logic [dataWidth-1:0] a;
		logic [dataWidth-1:0] second;
		logic [dataWidth-1:0] target;
	} evalInT;

	typedef struct packed {
		logic valid;
		kindT kind;
		logic take;
		logic [dataWidth-1:0] target;
	} evalOutT;

endpackage

`default_nettype wire

//--- rtl/branchDecode.sv
`default_nettype none

module branchDecode (
	input logic clk,
	input logic rst,
	input branchPkg::slotInT [branchPkg::laneCount-1:0] slots,
	input logic rsf,
	output branchPkg::evalInT [branchPkg::laneCount-1:0] decoded
);

	// trap codes 0..9 line up with condEq..condGeu
	function automatic branchPkg::condT trapCond(input logic [3:0] code);
		if (code <= branchPkg::trapCodeMax)
			return branchPkg::condT'(code + 4'd2);
		return branchPkg::condNever;
	endfunction

	// fold one slot's format fields into kind, cond and second operand
	function automatic branchPkg::evalInT decodeSlot(
		input branchPkg::slotInT s,
		input logic rsfLevel
	);
		logic [6:0] opcode;
		branchPkg::evalInT d;
		opcode = s.ir[31:25];
		d.valid = s.valid;
		d.kind = branchPkg::kindBranch;
		d.cond = branchPkg::condNever;
		d.a = s.a;
		// immediate formats are the common case
		d.second = s.imm;
		d.target = s.target;
		case (opcode)
			branchPkg::opBtrr: begin
				// func5 of 16 and up selects the unhandled indirect forms
				d.cond = s.ir[4] ? branchPkg::condNever : branchPkg::condT'(s.ir[3:0]);
				d.second = s.b;
			end
			branchPkg::opBtri: begin
				if (s.ir[14:11] < branchPkg::btriCodeLimit)
					d.cond = branchPkg::condT'(s.ir[14:11]);
			end
			branchPkg::opTrapcc: begin
				d.kind = branchPkg::kindTrap;
				d.cond = trapCond(s.ir[3:0]);
				d.second = s.b;
			end
			branchPkg::opTrapcci: begin
				d.kind = branchPkg::kindTrap;
				d.cond = trapCond(s.ir[18:15]);
			end
			branchPkg::opBeqi: d.cond = branchPkg::condEq;
			branchPkg::opBnei: d.cond = branchPkg::condNe;
			branchPkg::opBlti: d.cond = branchPkg::condLt;
			branchPkg::opBlei: d.cond = branchPkg::condLe;
			branchPkg::opBgti: d.cond = branchPkg::condGt;
			branchPkg::opBgei: d.cond = branchPkg::condGe;
			branchPkg::opBltui: d.cond = branchPkg::condLtu;
			branchPkg::opBleui: d.cond = branchPkg::condLeu;
			branchPkg::opBgtui: d.cond = branchPkg::condGtu;
			branchPkg::opBgeui: d.cond = branchPkg::condGeu;
			default: d.kind = branchPkg::kindNone;
		endcase
		// bnr carries the reservation flag in place of the second operand
		if (d.cond == branchPkg::condNr)
			d.second = {{(branchPkg::dataWidth-1){1'b0}}, rsfLevel};
		return d;
	endfunction

	// ==============================
	// decode register
	// ==============================
	always_ff @(posedge clk) begin
		for (int i = 0; i < branchPkg::laneCount; i++) begin
			if (rst) begin
				// empty pipeline slot
				decoded[i].valid <= 1'b0;
			end else begin
				decoded[i] <= decodeSlot(slots[i], rsf);
			end
		end
	end

endmodule

`default_nettype wire

//--- branchEval/branchEval.sv
`default_nettype none

module branchEval (
	input logic clk,
	input logic rst,
	input branchPkg::evalInT in,
	output branchPkg::evalOutT out
);

	// ==============================
	// compare flags
	// ==============================
	logic aZero;
	logic sZero;
	logic eq;
	logic lt;
	logic ltu;
	logic takeNext;

	assign aZero = in.a == '0;
	assign sZero = in.second == '0;
	assign eq = in.a == in.second;
	// two's complement compare
	assign lt = $signed(in.a) < $signed(in.second);
	assign ltu = in.a < in.second;

	// ==============================
	// condition select
	// ==============================
	always_comb begin
		case (in.cond)
			branchPkg::condAlways: takeNext = 1'b1;
			branchPkg::condNever: takeNext = 1'b0;
			branchPkg::condEq: takeNext = eq;
			branchPkg::condNe: takeNext = !eq;
			branchPkg::condLt: takeNext = lt;
			branchPkg::condLe: takeNext = lt | eq;
			branchPkg::condGt: takeNext = !(lt | eq);
			branchPkg::condGe: takeNext = !lt;
			// unsigned forms
			branchPkg::condLtu: takeNext = ltu;
			branchPkg::condLeu: takeNext = ltu | eq;
			branchPkg::condGtu: takeNext = !(ltu | eq);
			branchPkg::condGeu: takeNext = !ltu;
			// zero tests
			branchPkg::condOr: takeNext = !aZero || !sZero;
			branchPkg::condAnd: takeNext = !aZero && !sZero;
			// second holds rsf here, so taken when it is clear
			branchPkg::condNr: takeNext = sZero;
			branchPkg::condLoop: takeNext = !sZero;
			default: takeNext = 1'b0;
		endcase
	end

	// ==============================
	// result register
	// ==============================
	always_ff @(posedge clk) begin
		if (rst) begin
			out.valid <= 1'b0;
			out.take <= 1'b0;
		end else begin
			out.valid <= in.valid;
			// kindNone never takes
			out.take <= takeNext && (in.kind != branchPkg::kindNone);
		end
		// payload follows its slot
		out.kind <= in.kind;
		out.target <= in.target;
	end

endmodule

`default_nettype wire

//--- rtl/redirectArbiter.sv
`default_nettype none

module redirectArbiter (
	input logic clk,
	input logic rst,
	input branchPkg::evalOutT [branchPkg::laneCount-1:0] results,
	output logic redirect,
	output logic [branchPkg::dataWidth-1:0] redirectTarget,
	output logic trap,
	output branchPkg::laneIdxT trapLane,
	output logic [branchPkg::laneCount-1:0] squash
);

	logic found;
	branchPkg::laneIdxT sel;
	logic [branchPkg::laneCount-1:0] youngMask;
	logic selTrap;

	// ==============================
	// priority scan, lane 0 oldest
	// ==============================
	always_comb begin
		found = 1'b0;
		sel = '0;
		youngMask = '0;
		for (int i = 0; i < branchPkg::laneCount; i++) begin
			if (found) begin
				// everything after the winner is squashed
				youngMask[i] = results[i].valid;
			end else if (results[i].valid && results[i].take &&
					results[i].kind != branchPkg::kindNone) begin
				found = 1'b1;
				sel = branchPkg::laneIdxT'(i);
			end
		end
	end

	assign selTrap = results[sel].kind == branchPkg::kindTrap;

	// ==============================
	// output register
	// ==============================
	always_ff @(posedge clk) begin
		if (rst) begin
			redirect <= 1'b0;
			redirectTarget <= '0;
			trap <= 1'b0;
			trapLane <= '0;
			squash <= '0;
		end else begin
			redirect <= found && !selTrap;
			trap <= found && selTrap;
			// quiet outputs when nothing wins
			redirectTarget <= (found && !selTrap) ? results[sel].target : '0;
			trapLane <= (found && selTrap) ? sel : '0;
			squash <= youngMask;
		end
	end

endmodule

`default_nettype wire

//--- rtl/branchUnit.sv
`default_nettype none

module branchUnit (
	input logic clk,
	input logic rst,
	input branchPkg::slotInT [branchPkg::laneCount-1:0] slots,
	input logic rsf,
	output logic redirect,
	output logic [branchPkg::dataWidth-1:0] redirectTarget,
	output logic trap,
	output branchPkg::laneIdxT trapLane,
	output logic [branchPkg::laneCount-1:0] squash
);

	// stage 1 to stage 2
	branchPkg::evalInT [branchPkg::laneCount-1:0] decoded;
	// stage 2 to stage 3
	branchPkg::evalOutT [branchPkg::laneCount-1:0] results;

	// ==============================
	// stage 1, decode
	// ==============================
	branchDecode branchDecode_inst (
		.clk(clk),
		.rst(rst),
		.slots(slots),
		.rsf(rsf),
		.decoded(decoded)
	);

	// ==============================
	// stage 2, one lane per slot
	// ==============================
	for (genvar g = 0; g < branchPkg::laneCount; g++) begin : genLane
		branchEval branchEval_inst (
			.clk(clk),
			.rst(rst),
			.in(decoded[g]),
			.out(results[g])
		);
	end

	// ==============================
	// stage 3, arbitrate
	// ==============================
	redirectArbiter redirectArbiter_inst (
		.clk(clk),
		.rst(rst),
		.results(results),
		.redirect(redirect),
		.redirectTarget(redirectTarget),
		.trap(trap),
		.trapLane(trapLane),
		.squash(squash)
	);

endmodule

`default_nettype wire

//--- testbench/branchModel.svh
`ifndef branchModelSvh
`define branchModelSvh

// expected outputs of one issue group
typedef struct packed {
	logic redirect;
	logic [branchPkg::dataWidth-1:0] redirectTarget;
	logic trap;
	branchPkg::laneIdxT trapLane;
	logic [branchPkg::laneCount-1:0] squash;
} expectT;

// code numbering is the btrr function code, 0 always through 15 loop
function automatic logic condHolds(
	input int code,
	input logic [branchPkg::dataWidth-1:0] x,
	input logic [branchPkg::dataWidth-1:0] y,
	input logic rsfLevel
);
	case (code)
		0: return 1'b1;
		2: return x == y;
		3: return x != y;
		4: return $signed(x) < $signed(y);
		5: return $signed(x) <= $signed(y);
		6: return $signed(x) > $signed(y);
		7: return $signed(x) >= $signed(y);
		8: return x < y;
		9: return x <= y;
		10: return x > y;
		11: return x >= y;
		12: return x != 0 || y != 0;
		13: return x != 0 && y != 0;
		// reservation flag clear
		14: return !rsfLevel;
		15: return y != 0;
		// never, and every unused code
		default: return 1'b0;
	endcase
endfunction

// returns {isTrap, taken} for one slot
function automatic logic [1:0] slotOutcome(input branchPkg::slotInT s, input logic rsfLevel);
	logic isTrap;
	logic taken;
	isTrap = 1'b0;
	taken = 1'b0;
	case (s.ir[31:25])
		branchPkg::opBtrr: taken = condHolds(int'(s.ir[4:0]), s.a, s.b, rsfLevel);
		branchPkg::opBtri: begin
			if (s.ir[14:11] < 4'd12)
				taken = condHolds(int'(s.ir[14:11]), s.a, s.imm, rsfLevel);
		end
		// trap code k is eq for 0, ne for 1, up to geu for 9
		branchPkg::opTrapcc: begin
			isTrap = 1'b1;
			if (s.ir[3:0] <= 4'd9)
				taken = condHolds(int'(s.ir[3:0]) + 2, s.a, s.b, rsfLevel);
		end
		branchPkg::opTrapcci: begin
			isTrap = 1'b1;
			if (s.ir[18:15] <= 4'd9)
				taken = condHolds(int'(s.ir[18:15]) + 2, s.a, s.imm, rsfLevel);
		end
		branchPkg::opBeqi: taken = condHolds(2, s.a, s.imm, rsfLevel);
		branchPkg::opBnei: taken = condHolds(3, s.a, s.imm, rsfLevel);
		branchPkg::opBlti: taken = condHolds(4, s.a, s.imm, rsfLevel);
		branchPkg::opBlei: taken = condHolds(5, s.a, s.imm, rsfLevel);
		branchPkg::opBgti: taken = condHolds(6, s.a, s.imm, rsfLevel);
		branchPkg::opBgei: taken = condHolds(7, s.a, s.imm, rsfLevel);
		branchPkg::opBltui: taken = condHolds(8, s.a, s.imm, rsfLevel);
		branchPkg::opBleui: taken = condHolds(9, s.a, s.imm, rsfLevel);
		branchPkg::opBgtui: taken = condHolds(10, s.a, s.imm, rsfLevel);
		branchPkg::opBgeui: taken = condHolds(11, s.a, s.imm, rsfLevel);
		default: taken = 1'b0;
	endcase
	return {isTrap, taken && s.valid};
endfunction

// oldest taken slot wins, younger valid slots are squashed
function automatic expectT groupOutcome(
	input branchPkg::slotInT [branchPkg::laneCount-1:0] group,
	input logic rsfLevel
);
	expectT e;
	logic [1:0] r;
	logic found;
	e = '0;
	found = 1'b0;
	for (int i = 0; i < branchPkg::laneCount; i++) begin
		r = slotOutcome(group[i], rsfLevel);
		if (found) begin
			e.squash[i] = group[i].valid;
		end else if (r[0]) begin
			found = 1'b1;
			e.trap = r[1];
			e.redirect = !r[1];
			if (r[1])
				e.trapLane = branchPkg::laneIdxT'(i);
			else
				e.redirectTarget = group[i].target;
		end
	end
	return e;
endfunction

`endif

//--- testbench/branchUnitTb.sv
`default_nettype none

module branchUnitTb;
	timeunit 1ns;
	timeprecision 1ps;

	`include "branchModel.svh"

	typedef struct packed {
		branchPkg::slotInT [branchPkg::laneCount-1:0] slots;
		logic rsf;
	} groupT;

	// expected outcome and the cycle it shows up
	typedef struct {
		expectT exp;
		int due;
	} pendingT;

	logic clk;
	logic rst;
	branchPkg::slotInT [branchPkg::laneCount-1:0] slots;
	logic rsf;
	logic redirect;
	logic [branchPkg::dataWidth-1:0] redirectTarget;
	logic trap;
	branchPkg::laneIdxT trapLane;
	logic [branchPkg::laneCount-1:0] squash;

	groupT stimQ[$];
	pendingT expQ[$];
	groupT cur;
	pendingT want;
	int cycle = 0;
	int errorCount = 0;
	int checkCount = 0;
	int groupCount = 0;

	// operand pairs: equal, sign boundaries, zero
	logic [63:0] pairA [8] = '{64'd0, 64'd5, 64'd1, {64{1'b1}},
		64'h7fff_ffff_ffff_ffff, 64'h8000_0000_0000_0000, 64'd0, 64'd7};
	logic [63:0] pairB [8] = '{64'd0, 64'd5, {64{1'b1}}, 64'd1,
		64'h8000_0000_0000_0000, 64'h7fff_ffff_ffff_ffff, 64'd7, 64'd0};

	branchUnit branchUnit_inst (
		.clk(clk),
		.rst(rst),
		.slots(slots),
		.rsf(rsf),
		.redirect(redirect),
		.redirectTarget(redirectTarget),
		.trap(trap),
		.trapLane(trapLane),
		.squash(squash)
	);

	// 8 ns clock
	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk) cycle <= cycle + 1;

	function automatic branchPkg::slotInT makeSlot(input logic [31:0] ir,
			input logic [63:0] a, input logic [63:0] b, input logic [63:0] imm);
		branchPkg::slotInT s;
		s.valid = 1'b1;
		s.ir = ir;
		s.a = a;
		s.b = b;
		s.imm = imm;
		s.target = {$urandom(), $urandom()};
		return s;
	endfunction

	function automatic branchPkg::slotInT randomSlot();
		logic [6:0] ops [16];
		branchPkg::slotInT s;
		// the fourteen known opcodes plus two undefined ones
		ops = '{branchPkg::opBtrr, branchPkg::opBtri, branchPkg::opTrapcc,
			branchPkg::opTrapcci, branchPkg::opBeqi, branchPkg::opBnei, branchPkg::opBlti,
			branchPkg::opBlei, branchPkg::opBgti, branchPkg::opBgei, branchPkg::opBltui,
			branchPkg::opBleui, branchPkg::opBgtui, branchPkg::opBgeui, 7'd0, 7'd127};
		s = makeSlot({ops[$urandom_range(0, 15)], 25'($urandom())},
			{$urandom(), $urandom()}, {$urandom(), $urandom()}, {$urandom(), $urandom()});
		// equal operands now and then
		if ($urandom_range(0, 3) == 0)
			s.b = s.a;
		if ($urandom_range(0, 3) == 0)
			s.imm = s.a;
		s.valid = $urandom_range(0, 7) != 0;
		return s;
	endfunction

	task automatic addPair(input branchPkg::slotInT s0, input branchPkg::slotInT s1,
			input logic rsfLevel);
		groupT g;
		g.slots[0] = s0;
		g.slots[1] = s1;
		g.rsf = rsfLevel;
		stimQ.push_back(g);
	endtask

	// one valid slot, the other lane empty
	task automatic addSingle(input branchPkg::slotInT s, input int lane, input logic rsfLevel);
		if (lane == 0)
			addPair(s, '0, rsfLevel);
		else
			addPair('0, s, rsfLevel);
	endtask

	task automatic buildStimulus();
		logic [6:0] singleOps [10];
		singleOps = '{branchPkg::opBeqi, branchPkg::opBnei, branchPkg::opBlti,
			branchPkg::opBlei, branchPkg::opBgti, branchPkg::opBgei, branchPkg::opBltui,
			branchPkg::opBleui, branchPkg::opBgtui, branchPkg::opBgeui};
		// ==============================
		// idle and kindNone groups
		// ==============================
		repeat (4) addPair('0, '0, 1'b0);
		addPair(makeSlot(32'h0000_1234, 64'd5, 64'd5, 64'd5),
			makeSlot({7'd127, 25'd0}, 64'd0, 64'd0, 64'd0), 1'b0);
		// ==============================
		// every code against every operand pair
		// ==============================
		for (int p = 0; p < 8; p++) begin
			// btrr codes 16 and up are the indirect forms
			for (int c = 0; c < 32; c++)
				addSingle(makeSlot({branchPkg::opBtrr, 20'd0, 5'(c)}, pairA[p], pairB[p],
					~pairB[p]), (c + p) % 2, p[1]);
			for (int c = 0; c < 16; c++) begin
				addSingle(makeSlot({branchPkg::opBtri, 10'd0, 4'(c), 11'd0}, pairA[p],
					~pairB[p], pairB[p]), c % 2, p[0]);
				addSingle(makeSlot({branchPkg::opTrapcc, 21'd0, 4'(c)}, pairA[p], pairB[p],
					64'd3), (c + p) % 2, 1'b0);
				addSingle(makeSlot({branchPkg::opTrapcci, 6'd0, 4'(c), 15'd0}, pairA[p],
					64'd9, pairB[p]), c % 2, 1'b0);
			end
			for (int k = 0; k < 10; k++)
				addSingle(makeSlot({singleOps[k], 25'd0}, pairA[p], 64'd0, pairB[p]),
					(k + p) % 2, 1'b0);
		end
		// ==============================
		// priority and squash
		// ==============================
		addPair(makeSlot({branchPkg::opBtrr, 25'd0}, 64'd1, 64'd2, 64'd0),
			makeSlot({branchPkg::opBtrr, 25'd0}, 64'd3, 64'd4, 64'd0), 1'b0);
		addPair(makeSlot({branchPkg::opTrapcc, 25'd0}, 64'd6, 64'd6, 64'd0),
			makeSlot({branchPkg::opBtrr, 25'd0}, 64'd3, 64'd4, 64'd0), 1'b0);
		addPair(makeSlot({branchPkg::opBtrr, 25'd1}, 64'd1, 64'd2, 64'd0),
			makeSlot({branchPkg::opBtrr, 25'd0}, 64'd3, 64'd4, 64'd0), 1'b0);
		addPair(makeSlot({branchPkg::opBtrr, 25'd1}, 64'd1, 64'd2, 64'd0),
			makeSlot({branchPkg::opTrapcci, 25'd0}, 64'd8, 64'd0, 64'd8), 1'b0);
		// back-to-back random groups
		repeat (200) addPair(randomSlot(), randomSlot(), 1'($urandom_range(0, 1)));
	endtask

	task automatic reportMismatch(input string name, input logic [63:0] got,
			input logic [63:0] exp);
		$display("CHECK FAILED time=%0t %s got=%0h expected=%0h", $time, name, got, exp);
		errorCount++;
	endtask

	// outputs settle well before the falling edge
	always @(negedge clk) begin
		if (!rst) begin
			if (expQ.size() != 0 && expQ[0].due == cycle) begin
				want = expQ.pop_front();
				checkCount++;
				assert (redirect === want.exp.redirect)
					else reportMismatch("redirect", redirect, want.exp.redirect);
				assert (redirectTarget === want.exp.redirectTarget)
					else reportMismatch("redirectTarget", redirectTarget, want.exp.redirectTarget);
				assert (trap === want.exp.trap)
					else reportMismatch("trap", trap, want.exp.trap);
				assert (trapLane === want.exp.trapLane)
					else reportMismatch("trapLane", trapLane, want.exp.trapLane);
				assert (squash === want.exp.squash)
					else reportMismatch("squash", squash, want.exp.squash);
			end else begin
				// no group due, so everything must stay quiet
				assert (redirect === 1'b0 && trap === 1'b0 && squash === '0) else begin
					$display("ERROR: output strobe at time %0t while no group is due (%0d queued)",
						$time, expQ.size());
					errorCount++;
				end
			end
		end
	end

	initial begin
		void'($urandom(32'h9a8ba715));
		rst = 1'b1;
		slots = '0;
		rsf = 1'b0;
		buildStimulus();
		groupCount = stimQ.size();
		repeat (5) @(posedge clk);
		#1;
		rst = 1'b0;
		// one group per cycle, result due three edges later
		while (stimQ.size() != 0) begin
			cur = stimQ.pop_front();
			slots = cur.slots;
			rsf = cur.rsf;
			expQ.push_back('{exp: groupOutcome(cur.slots, cur.rsf), due: cycle + 3});
			@(posedge clk);
			#1;
		end
		slots = '0;
		rsf = 1'b0;
		while (expQ.size() != 0)
			@(posedge clk);
		repeat (3) @(posedge clk);
		$display("summary: %0d groups, %0d checks, %0d errors", groupCount, checkCount,
			errorCount);
		if (errorCount == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

	// watchdog sized from the group count
	initial begin
		wait (groupCount > 0);
		#((groupCount + 20) * 8);
		$display("ERROR: watchdog expired after %0d cycles, the run did not finish",
			groupCount + 20);
		$display("Test failures found");
		$finish;
	end

endmodule

`default_nettype wire

//--- branchUnit.f
+incdir+testbench
common/branchPkg.sv
rtl/branchDecode.sv
branchEval/branchEval.sv
rtl/redirectArbiter.sv
rtl/branchUnit.sv
testbench/branchUnitTb.sv

//--- Bender.yml
package:
  name: branch_unit

sources:
  # package first, then the design bottom-up
  - files:
      - common/branchPkg.sv
      - rtl/branchDecode.sv
      - branchEval/branchEval.sv
      - rtl/redirectArbiter.sv
      - rtl/branchUnit.sv

  # testbench and its model header
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/branchUnitTb.sv
